// ==== Makefile ====
# Verilator build, run, lint and clean for crypto_bus
# Any variable below can be overridden, e.g. make JOBS=8 LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_crypto_bus
RTL_TOP   ?= crypto_bus_top
FILELIST  ?= crypto_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, since the simulator exits cleanly either way
run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== apb_channel/apb_channel.sv ====
// APB bridge with transfer FSM, read data capture and interrupt pending flag

`timescale 1ns/10ps

module apb_channel
  import bus_map_pkg::*, apb_pkg::*;
#(
  parameter int APB_ADDR_WIDTH = APB_ADDR_WIDTH_DEFAULT
) (
  input  logic                      clock,
  input  logic                      reset,

  // Router side
  bus_chan_if.channel               chan,

  // APB manager port toward the accelerator
  output logic [APB_ADDR_WIDTH-1:0] paddr_o,
  output logic                      psel_o,
  output logic                      penable_o,
  output logic                      pwrite_o,
  output data_t                     pwdata_o,
  input  data_t                     prdata_i,
  input  logic                      pready_i,

  // Interrupt line and its acknowledge
  input  logic                      irq_i,
  input  logic                      irq_response_i,
  output logic                      pending_o
);

  apb_state_t                state_q;
  logic                      start;
  logic                      done;

  logic [APB_ADDR_WIDTH-1:0] paddr_q;
  logic                      pwrite_q;
  data_t                     pwdata_q;
  data_t                     read_data_q;
  logic                      response_q;

  logic                      irq_q;
  logic                      pending_q;

  // --------------------------------------------------
  // Transfer sequencing
  // --------------------------------------------------

  assign start = chan.read_request || chan.write_request;

  // Transfer completes on the first ready enable cycle
  assign done = (state_q == apb_enable) && pready_i;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= apb_idle;
    end else begin
      case (state_q)
        apb_idle: begin
          if (start) begin
            state_q <= apb_select;
          end
        end
        apb_select: begin
          state_q <= apb_enable;
        end
        apb_enable: begin
          if (pready_i) begin
            state_q <= apb_idle;
          end
        end
        default: begin
          state_q <= apb_idle;
        end
      endcase
    end
  end

  // Direction held for the whole transfer
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pwrite_q <= 1'b0;
    end else if (state_q == apb_idle && start) begin
      pwrite_q <= chan.write_request;
    end
  end

  // Address and write data taken with the request
  always_ff @(posedge clock) begin
    if (state_q == apb_idle && start) begin
      paddr_q  <= chan.offset;
      pwdata_q <= chan.write_data;
    end
  end

  assign paddr_o   = paddr_q;
  assign pwrite_o  = pwrite_q;
  assign pwdata_o  = pwdata_q;
  assign psel_o    = (state_q == apb_select) || (state_q == apb_enable);
  assign penable_o = (state_q == apb_enable);

  // --------------------------------------------------
  // Response toward the router
  // --------------------------------------------------

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      response_q <= 1'b0;
    end else begin
      response_q <= done;
    end
  end

  always_ff @(posedge clock) begin
    if (done && !pwrite_q) begin
      read_data_q <= prdata_i;
    end
  end

  assign chan.response  = response_q;
  assign chan.read_data = read_data_q;

  // --------------------------------------------------
  // Interrupt capture
  // --------------------------------------------------

  // New edge takes priority over the acknowledge
  always_ff @(posedge clock) begin
    if (reset) begin
      irq_q     <= 1'b0;
      pending_q <= 1'b0;
    end else begin
      irq_q <= irq_i;
      if (irq_i && !irq_q) begin
        pending_q <= 1'b1;
      end else if (irq_response_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  assign pending_o = pending_q;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Enable phase only after a setup cycle
  a_setup_before_enable: assert property (@(posedge clock) disable iff (reset)
    penable_o |-> psel_o && $past(psel_o));

  // Address and direction frozen across the transfer
  a_ctrl_stable: assert property (@(posedge clock) disable iff (reset)
    (psel_o && $past(psel_o)) |-> $stable(paddr_o) && $stable(pwrite_o));

  // Router waits for the previous response
  a_request_when_idle: assert property (@(posedge clock) disable iff (reset)
    start |-> state_q == apb_idle);

endmodule

// ==== common/apb_pkg.sv ====
// APB address width default and bridge transfer state encoding

package apb_pkg;

  // Address slice forwarded to each accelerator
  localparam int APB_ADDR_WIDTH_DEFAULT = 12;

  // --------------------------------------------------
  // Bridge states
  // --------------------------------------------------

  // Idle until a request arrives
  // Select is the one-cycle setup phase
  // Enable holds until the target raises pready
  typedef enum logic [1:0] {
    apb_idle,
    apb_select,
    apb_enable
  } apb_state_t;

endpackage

// ==== common/bus_chan_if.sv ====
// Request and response channel between the bus router and one APB bridge

`timescale 1ns/10ps

interface bus_chan_if
  import bus_map_pkg::*, apb_pkg::*;
#(
  parameter int APB_ADDR_WIDTH = APB_ADDR_WIDTH_DEFAULT
) ();

  // Request side, single-cycle pulses
  logic                      read_request;
  logic                      write_request;

  // Offset inside the accelerator window
  logic [APB_ADDR_WIDTH-1:0] offset;
  data_t                     write_data;

  // Response side
  data_t                     read_data;
  logic                      response;

  // Router issues requests and waits for the response
  modport router (
    output read_request,
    output write_request,
    output offset,
    output write_data,
    input  read_data,
    input  response
  );

  // Bridge answers each request with one response pulse
  modport channel (
    input  read_request,
    input  write_request,
    input  offset,
    input  write_data,
    output read_data,
    output response
  );

endinterface

// ==== common/bus_map_pkg.sv ====
// Manager-side address and data types, accelerator window map and target encoding

package bus_map_pkg;

  // --------------------------------------------------
  // Manager bus widths
  // --------------------------------------------------

  // Byte address issued by the manager
  typedef logic [31:0] addr_t;

  // One bus data word
  typedef logic [31:0] data_t;

  // --------------------------------------------------
  // Accelerator windows
  // --------------------------------------------------

  // Each window spans 64 KiB
  localparam int WINDOW_BITS = 16;

  // Message-authentication engine
  localparam addr_t MAC_BASE = 32'h8005_0000;

  // Block-cipher engine
  localparam addr_t CIPHER_BASE = 32'h8006_0000;

  // What a manager address selects
  typedef enum logic [1:0] {
    target_mac,
    target_cipher,
    target_none
  } target_t;

  // --------------------------------------------------
  // Interrupts
  // --------------------------------------------------

  // Bit 0 mac, bit 1 cipher
  localparam int NUM_IRQ = 2;

endpackage

// ==== crypto_bus.f ====
common/bus_map_pkg.sv
common/apb_pkg.sv
common/bus_chan_if.sv
apb_channel/apb_channel.sv
src/bus_router.sv
src/crypto_bus_top.sv
sim/tb_crypto_bus.sv

// ==== sim/crypto_bus_testdata.txt ====
# op target offset data expected, all but op in hex
# op W write, R read, I interrupt; target 0 mac, 1 cipher, 2 unmapped; for I data is hold cycles
W 0 0004 a5a50001 00000000
R 0 0004 00000000 a5a50001
W 1 0004 5a5a0002 00000000
R 1 0004 00000000 5a5a0002
R 0 0004 00000000 a5a50001
W 0 0010 13572468 00000000
W 0 003c deadbeef 00000000
W 1 0020 0badf00d 00000000
W 1 0038 cafe0123 00000000
R 0 0010 00000000 13572468
R 1 0020 00000000 0badf00d
R 0 003c 00000000 deadbeef
R 1 0038 00000000 cafe0123
W 0 1008 11112222 00000000
R 0 0008 00000000 11112222
W 1 f014 33334444 00000000
R 1 0014 00000000 33334444
W 2 0004 ffffffff 00000000
R 2 0004 00000000 00000000
R 2 0100 00000000 00000000
W 0 0004 76543210 00000000
R 0 0004 00000000 76543210
R 1 0004 00000000 5a5a0002
I 0 0000 00000004 00000001
I 1 0000 00000006 00000002
R 0 0010 00000000 13572468
R 1 0038 00000000 cafe0123
R 0 0008 00000000 11112222

// ==== sim/tb_crypto_bus.sv ====
// Testbench for crypto_bus_top with file-driven stimulus, APB target models, checks and timeout

`timescale 1ns/10ps

module tb_crypto_bus
  import bus_map_pkg::*;
();

  localparam int    APB_ADDR_WIDTH = 12;
  localparam string TESTDATA_FILE  = "sim/crypto_bus_testdata.txt";
  localparam addr_t UNMAPPED_BASE  = 32'h8007_0000;
  // Longest operation in cycles, interrupt holds included
  localparam int    MAX_OP_CYCLES  = 32;
  localparam int    MARGIN_CYCLES  = 100;

  logic                      clock = 1'b0;
  logic                      reset = 1'b1;
  addr_t                     rw_address_i = '0;
  logic                      read_request_i = 1'b0;
  logic                      write_request_i = 1'b0;
  data_t                     write_data_i = '0;
  data_t                     read_data_o;
  logic                      read_response_o;
  logic                      write_response_o;
  logic [NUM_IRQ-1:0]        irq_ack = '0;
  logic [NUM_IRQ-1:0]        irq_line = '0;
  logic [NUM_IRQ-1:0]        irq_o;

  // APB side, index 0 mac and 1 cipher
  logic [APB_ADDR_WIDTH-1:0] paddr [2];
  logic [1:0]                psel;
  logic [1:0]                penable;
  logic [1:0]                pwrite;
  data_t                     pwdata [2];
  data_t                     prdata [2] = '{32'h0, 32'h0};
  logic [1:0]                pready = 2'b00;

  // Target model state
  data_t                     mem [2][16];
  int                        select_count [2] = '{0, 0};
  int                        waits_left [2] = '{0, 0};
  int                        last_waits [2] = '{0, 0};
  logic [APB_ADDR_WIDTH-1:0] last_paddr [2];
  logic [31:0]               lfsr_state = 32'hfdc2;
  string                     model_name [2] = '{"mac", "cipher"};

  // Operations read from the data file
  logic [7:0]                op_q [$];
  int                        tgt_q [$];
  logic [15:0]               off_q [$];
  data_t                     data_q [$];
  data_t                     exp_q [$];

  int                        error_count = 0;
  int                        check_count = 0;
  int                        test_count = 0;
  int                        cycle_count = 0;
  int                        cycle_limit = 0;

  crypto_bus_top #(.APB_ADDR_WIDTH(APB_ADDR_WIDTH)) UUT (
    .clock            (clock),
    .reset            (reset),
    .rw_address_i     (rw_address_i),
    .read_request_i   (read_request_i),
    .write_request_i  (write_request_i),
    .write_data_i     (write_data_i),
    .read_data_o      (read_data_o),
    .read_response_o  (read_response_o),
    .write_response_o (write_response_o),
    .irq_response_i   (irq_ack),
    .irq_o            (irq_o),
    .mac_prdata_i     (prdata[0]),
    .mac_pready_i     (pready[0]),
    .mac_irq_i        (irq_line[0]),
    .mac_paddr_o      (paddr[0]),
    .mac_psel_o       (psel[0]),
    .mac_penable_o    (penable[0]),
    .mac_pwrite_o     (pwrite[0]),
    .mac_pwdata_o     (pwdata[0]),
    .cipher_prdata_i  (prdata[1]),
    .cipher_pready_i  (pready[1]),
    .cipher_irq_i     (irq_line[1]),
    .cipher_paddr_o   (paddr[1]),
    .cipher_psel_o    (psel[1]),
    .cipher_penable_o (penable[1]),
    .cipher_pwrite_o  (pwrite[1]),
    .cipher_pwdata_o  (pwdata[1])
  );

  initial begin
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, a response never arrived", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------
  // APB target models
  // --------------------------------------------------

  // Galois LFSR, one step per bit taken
  function automatic logic random_bit();
    logic b;
    b = lfsr_state[0];
    if (lfsr_state[0]) begin
      lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_state = lfsr_state >> 1;
    end
    return b;
  endfunction

  always @(posedge clock) begin : target_models
    int n;
    for (int t = 0; t < 2; t++) begin
      if (reset) begin
        for (int w = 0; w < 16; w++) begin
          mem[t][w] <= 32'hc0de_0000 | (t << 8) | w;
        end
        pready[t]       <= 1'b0;
        select_count[t] <= 0;
      end else if (psel[t] && !penable[t]) begin
        // Setup cycle picks 0 to 3 wait states
        n = 0;
        if (random_bit()) begin
          n = n + 2;
        end
        if (random_bit()) begin
          n = n + 1;
        end
        select_count[t] <= select_count[t] + 1;
        last_paddr[t]   <= paddr[t];
        last_waits[t]   <= n;
        waits_left[t]   <= n;
        pready[t]       <= (n == 0);
        prdata[t]       <= mem[t][paddr[t][5:2]];
      end else if (psel[t] && penable[t]) begin
        if (pready[t]) begin
          if (pwrite[t]) begin
            mem[t][paddr[t][5:2]] <= pwdata[t];
          end
          pready[t] <= 1'b0;
        end else begin
          waits_left[t] <= waits_left[t] - 1;
          pready[t]     <= (waits_left[t] == 1);
        end
      end
    end
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------

  task automatic check_data(input data_t got, input data_t expected, input string what);
    check_count++;
    if (got !== expected) begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic check_flag(input logic got, input logic expected, input string what);
    check_count++;
    if (got !== expected) begin
      $display("Mismatch at time %0t: %s is %b, expected %b", $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic compare_latency(input int got, input int expected, input string what);
    check_count++;
    if (got != expected) begin
      $display("Mismatch at time %0t: %s took %0d cycles, expected %0d",
               $time, what, got, expected);
      error_count++;
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  task automatic read_testdata(output logic loaded);
    int          fd;
    int          code;
    string       line;
    logic [7:0]  op;
    int          tgt;
    logic [15:0] off;
    data_t       d;
    data_t       e;
    loaded = 1'b0;
    fd = $fopen(TESTDATA_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        // Hash lines describe the columns
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%c %d %h %h %h", op, tgt, off, d, e);
          if (code == 5) begin
            op_q.push_back(op);
            tgt_q.push_back(tgt);
            off_q.push_back(off);
            data_q.push_back(d);
            exp_q.push_back(e);
          end
        end
      end
      $fclose(fd);
      loaded = 1'b1;
    end
  endtask

  function automatic addr_t window_address(input int tgt, input logic [15:0] offset);
    case (tgt)
      0:       return MAC_BASE | addr_t'(offset);
      1:       return CIPHER_BASE | addr_t'(offset);
      default: return UNMAPPED_BASE | addr_t'(offset);
    endcase
  endfunction

  task automatic bus_transfer(input logic is_write, input int tgt, input logic [15:0] offset,
                              input data_t wdata, input data_t expected);
    int    sel_before [2];
    int    latency;
    int    exp_latency;
    logic  got_response;
    logic  saw_read;
    logic  saw_write;
    data_t rdata;
    sel_before = select_count;
    @(posedge clock);
    rw_address_i    <= window_address(tgt, offset);
    write_data_i    <= wdata;
    read_request_i  <= !is_write;
    write_request_i <= is_write;
    latency      = 0;
    got_response = 1'b0;
    saw_read     = 1'b0;
    saw_write    = 1'b0;
    rdata        = '0;
    while (!got_response) begin
      @(posedge clock);
      latency++;
      // Request pulse lasts one cycle
      read_request_i  <= 1'b0;
      write_request_i <= 1'b0;
      @(negedge clock);
      if (read_response_o || write_response_o) begin
        got_response = 1'b1;
        saw_read     = read_response_o;
        saw_write    = write_response_o;
        rdata        = read_data_o;
      end
    end
    check_flag(saw_read, !is_write, "read_response_o");
    check_flag(saw_write, is_write, "write_response_o");
    if (!is_write) begin
      check_data(rdata, expected, "read_data_o");
    end
    // Three cycles through select and enable, plus the model's wait states
    if (tgt < 2) begin
      exp_latency = 3 + last_waits[tgt];
      check_data(data_t'(last_paddr[tgt]), data_t'(offset[APB_ADDR_WIDTH-1:0]), "paddr");
    end else begin
      exp_latency = 1;
    end
    compare_latency(latency, exp_latency, "response");
    for (int t = 0; t < 2; t++) begin
      check_flag(select_count[t] != sel_before[t], t == tgt,
                 $sformatf("transfer seen by %s model", model_name[t]));
    end
    @(negedge clock);
    check_flag(read_response_o || write_response_o, 1'b0, "response in the next cycle");
  endtask

  task automatic interrupt_sequence(input int line, input int hold_cycles,
                                    input logic [1:0] expected);
    int other;
    other = 1 - line;
    @(posedge clock);
    irq_line[line] <= 1'b1;
    @(posedge clock);
    @(negedge clock);
    check_flag(irq_o[line], expected[line], "irq_o after rising edge");
    check_flag(irq_o[other], expected[other], "irq_o of the other line");
    // Acknowledge while the input stays high
    @(posedge clock);
    irq_ack[line] <= 1'b1;
    @(posedge clock);
    irq_ack[line] <= 1'b0;
    @(negedge clock);
    check_flag(irq_o[line], 1'b0, "irq_o after acknowledge");
    repeat (hold_cycles) begin
      @(negedge clock);
      check_flag(irq_o[line], 1'b0, "irq_o with input held high");
    end
    // Only a new edge sets it again
    @(posedge clock);
    irq_line[line] <= 1'b0;
    @(posedge clock);
    irq_line[line] <= 1'b1;
    @(posedge clock);
    @(negedge clock);
    check_flag(irq_o[line], 1'b1, "irq_o after a new edge");
    @(posedge clock);
    irq_line[line] <= 1'b0;
    irq_ack[line]  <= 1'b1;
    @(posedge clock);
    irq_ack[line] <= 1'b0;
    @(negedge clock);
    check_flag(irq_o[line], 1'b0, "irq_o after final acknowledge");
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin : stimulus
    logic  loaded;
    int    errors_before;
    string desc;
    read_testdata(loaded);
    if (!loaded || op_q.size() == 0) begin
      $display("Could not read any operation from %s", TESTDATA_FILE);
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      cycle_limit = 10 + op_q.size() * MAX_OP_CYCLES + MARGIN_CYCLES;
      repeat (10) @(posedge clock);
      reset <= 1'b0;
      @(negedge clock);
      errors_before = error_count;
      for (int t = 0; t < 2; t++) begin
        check_flag(psel[t], 1'b0, $sformatf("%s psel after reset", model_name[t]));
        check_flag(penable[t], 1'b0, $sformatf("%s penable after reset", model_name[t]));
        check_flag(irq_o[t], 1'b0, "irq_o after reset");
      end
      check_flag(read_response_o, 1'b0, "read_response_o after reset");
      check_flag(write_response_o, 1'b0, "write_response_o after reset");
      test_count++;
      $display("test %0d reset: %s", test_count, (error_count == errors_before) ? "ok" : "error");
      for (int i = 0; i < op_q.size(); i++) begin
        errors_before = error_count;
        desc = $sformatf("%c target %0d offset %h", op_q[i], tgt_q[i], off_q[i]);
        case (op_q[i])
          "W": bus_transfer(1'b1, tgt_q[i], off_q[i], data_q[i], exp_q[i]);
          "R": bus_transfer(1'b0, tgt_q[i], off_q[i], data_q[i], exp_q[i]);
          "I": interrupt_sequence(tgt_q[i], int'(data_q[i]), exp_q[i][1:0]);
          default: begin
            $display("Unknown op code on data line %0d", i);
            error_count++;
          end
        endcase
        test_count++;
        $display("test %0d %s: %s", test_count, desc,
                 (error_count == errors_before) ? "ok" : "error");
      end
      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

// ==== src/bus_router.sv ====
// Window decode, request steering, response and read data merge, interrupt packing

`timescale 1ns/10ps

module bus_router
  import bus_map_pkg::*;
(
  input  logic               clock,
  input  logic               reset,

  // Manager request/response bus
  input  addr_t              rw_address_i,
  input  logic               read_request_i,
  input  logic               write_request_i,
  input  data_t              write_data_i,
  output data_t              read_data_o,
  output logic               read_response_o,
  output logic               write_response_o,

  // Interrupts toward the manager
  output logic [NUM_IRQ-1:0] irq_o,

  // Bridge channels
  bus_chan_if.router         mac_chan,
  bus_chan_if.router         cipher_chan,
  input  logic               mac_pending_i,
  input  logic               cipher_pending_i
);

  localparam int ADDR_BITS    = $bits(addr_t);
  localparam int OFFSET_WIDTH = $bits(mac_chan.offset);

  target_t target;
  logic    any_request;
  logic    any_response;
  logic    outstanding_q;
  logic    is_read_q;
  logic    none_response_q;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------

  always_comb begin
    if (rw_address_i[ADDR_BITS-1:WINDOW_BITS] == MAC_BASE[ADDR_BITS-1:WINDOW_BITS]) begin
      target = target_mac;
    end else if (rw_address_i[ADDR_BITS-1:WINDOW_BITS] ==
                 CIPHER_BASE[ADDR_BITS-1:WINDOW_BITS]) begin
      target = target_cipher;
    end else begin
      target = target_none;
    end
  end

  assign any_request = read_request_i || write_request_i;

  // Only the selected channel sees the pulse
  assign mac_chan.read_request     = read_request_i && (target == target_mac);
  assign mac_chan.write_request    = write_request_i && (target == target_mac);
  assign cipher_chan.read_request  = read_request_i && (target == target_cipher);
  assign cipher_chan.write_request = write_request_i && (target == target_cipher);

  assign mac_chan.offset       = rw_address_i[OFFSET_WIDTH-1:0];
  assign mac_chan.write_data   = write_data_i;
  assign cipher_chan.offset    = rw_address_i[OFFSET_WIDTH-1:0];
  assign cipher_chan.write_data = write_data_i;

  // --------------------------------------------------
  // Request tracking
  // --------------------------------------------------

  assign any_response = mac_chan.response || cipher_chan.response || none_response_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      outstanding_q   <= 1'b0;
      is_read_q       <= 1'b0;
      none_response_q <= 1'b0;
    end else begin
      // Unmapped addresses answered one cycle later
      none_response_q <= any_request && (target == target_none);
      if (any_request) begin
        outstanding_q <= 1'b1;
        is_read_q     <= read_request_i;
      end else if (any_response) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Merge toward the manager
  // --------------------------------------------------

  assign read_response_o  = any_response && is_read_q;
  assign write_response_o = any_response && !is_read_q;

  // Zero data unless a bridge is responding
  always_comb begin
    if (mac_chan.response) begin
      read_data_o = mac_chan.read_data;
    end else if (cipher_chan.response) begin
      read_data_o = cipher_chan.read_data;
    end else begin
      read_data_o = '0;
    end
  end

  assign irq_o = {cipher_pending_i, mac_pending_i};

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Manager waits for each response
  a_single_outstanding: assert property (@(posedge clock) disable iff (reset)
    outstanding_q |-> !any_request);

  a_one_direction: assert property (@(posedge clock) disable iff (reset)
    !(read_request_i && write_request_i));

endmodule

// ==== src/crypto_bus_top.sv ====
// Top level joining the bus router with the mac and cipher APB bridges

`timescale 1ns/10ps

module crypto_bus_top
  import bus_map_pkg::*, apb_pkg::*;
#(
  parameter int APB_ADDR_WIDTH = APB_ADDR_WIDTH_DEFAULT
) (
  input  logic                      clock,
  input  logic                      reset,

  // Manager bus
  input  addr_t                     rw_address_i,
  input  logic                      read_request_i,
  input  logic                      write_request_i,
  input  data_t                     write_data_i,
  output data_t                     read_data_o,
  output logic                      read_response_o,
  output logic                      write_response_o,

  // Interrupts
  input  logic [NUM_IRQ-1:0]        irq_response_i,
  output logic [NUM_IRQ-1:0]        irq_o,

  // mac accelerator
  input  data_t                     mac_prdata_i,
  input  logic                      mac_pready_i,
  input  logic                      mac_irq_i,
  output logic [APB_ADDR_WIDTH-1:0] mac_paddr_o,
  output logic                      mac_psel_o,
  output logic                      mac_penable_o,
  output logic                      mac_pwrite_o,
  output data_t                     mac_pwdata_o,

  // cipher accelerator
  input  data_t                     cipher_prdata_i,
  input  logic                      cipher_pready_i,
  input  logic                      cipher_irq_i,
  output logic [APB_ADDR_WIDTH-1:0] cipher_paddr_o,
  output logic                      cipher_psel_o,
  output logic                      cipher_penable_o,
  output logic                      cipher_pwrite_o,
  output data_t                     cipher_pwdata_o
);

  logic mac_pending;
  logic cipher_pending;

  bus_chan_if #(.APB_ADDR_WIDTH(APB_ADDR_WIDTH)) mac_bus ();
  bus_chan_if #(.APB_ADDR_WIDTH(APB_ADDR_WIDTH)) cipher_bus ();

  bus_router router (
    .clock            (clock),
    .reset            (reset),
    .rw_address_i     (rw_address_i),
    .read_request_i   (read_request_i),
    .write_request_i  (write_request_i),
    .write_data_i     (write_data_i),
    .read_data_o      (read_data_o),
    .read_response_o  (read_response_o),
    .write_response_o (write_response_o),
    .irq_o            (irq_o),
    .mac_chan         (mac_bus),
    .cipher_chan      (cipher_bus),
    .mac_pending_i    (mac_pending),
    .cipher_pending_i (cipher_pending)
  );

  // --------------------------------------------------
  // Accelerator bridges
  // --------------------------------------------------

  apb_channel #(.APB_ADDR_WIDTH(APB_ADDR_WIDTH)) mac_channel (
    .clock          (clock),
    .reset          (reset),
    .chan           (mac_bus),
    .paddr_o        (mac_paddr_o),
    .psel_o         (mac_psel_o),
    .penable_o      (mac_penable_o),
    .pwrite_o       (mac_pwrite_o),
    .pwdata_o       (mac_pwdata_o),
    .prdata_i       (mac_prdata_i),
    .pready_i       (mac_pready_i),
    .irq_i          (mac_irq_i),
    .irq_response_i (irq_response_i[0]),
    .pending_o      (mac_pending)
  );

  apb_channel #(.APB_ADDR_WIDTH(APB_ADDR_WIDTH)) cipher_channel (
    .clock          (clock),
    .reset          (reset),
    .chan           (cipher_bus),
    .paddr_o        (cipher_paddr_o),
    .psel_o         (cipher_psel_o),
    .penable_o      (cipher_penable_o),
    .pwrite_o       (cipher_pwrite_o),
    .pwdata_o       (cipher_pwdata_o),
    .prdata_i       (cipher_prdata_i),
    .pready_i       (cipher_pready_i),
    .irq_i          (cipher_irq_i),
    .irq_response_i (irq_response_i[1]),
    .pending_o      (cipher_pending)
  );

endmodule
